// File: all.f
rtl/core_pkg.sv
rtl/exec_if.sv
rtl/wb_if.sv
rtl/reg_file.sv
rtl/issue_stage.sv
rtl/arith_unit.sv
rtl/logic_unit.sv
rtl/result_merge.sv
rtl/exec_core.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_core.sv

// File: testbench/tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

    logic        clk, reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        hlt;

    int seed;
    int cycle = 0;          // counts rising edges
    int err_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int test_base = 0;      // err_count at test start

    logic [63:0] model_regs [32];

    // expected writeback slots oldest first
    int          exp_slot [$];
    bit          exp_halt [$];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];

    logic [4:0] arith_ops [5] = '{core_pkg::op_add, core_pkg::op_addi, core_pkg::op_sub,
                                  core_pkg::op_subi, core_pkg::op_mul};
    logic [4:0] logic_ops [10] = '{core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor,
                                   core_pkg::op_not, core_pkg::op_shftr, core_pkg::op_shftri,
                                   core_pkg::op_shftl, core_pkg::op_shftli,
                                   core_pkg::op_mov_rs, core_pkg::op_mov_lit};
    // codes outside the kept set
    logic [4:0] undef_ops [16] = '{5'h08, 5'h09, 5'h0A, 5'h0B, 5'h0C, 5'h0D, 5'h0E, 5'h10,
                                   5'h13, 5'h14, 5'h15, 5'h16, 5'h17, 5'h1D, 5'h1E, 5'h1F};

    tb_clock_gen #(.period(20.0), .reset_cycles(5)) u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    exec_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .hlt         (hlt)
    );

    always @(posedge clk) cycle = cycle + 1;

    function int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // 1 writes rd, 2 halt, 0 bubble
    function int op_kind(input logic [4:0] op);
        case (op)
            core_pkg::op_add, core_pkg::op_addi, core_pkg::op_sub, core_pkg::op_subi,
            core_pkg::op_mul, core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor,
            core_pkg::op_not, core_pkg::op_shftr, core_pkg::op_shftri, core_pkg::op_shftl,
            core_pkg::op_shftli, core_pkg::op_mov_rs, core_pkg::op_mov_lit:
                return 1;
            core_pkg::op_halt: return 2;
            default:           return 0;
        endcase
    endfunction

    // reference result straight from the opcode rules
    function logic [63:0] model_result(input logic [4:0] op, input logic [63:0] rdv,
                                       input logic [63:0] rsv, input logic [63:0] rtv,
                                       input logic [11:0] lit);
        logic [63:0] l;
        l = {52'd0, lit};   // zero extended
        case (op)
            core_pkg::op_add:     return rsv + rtv;
            core_pkg::op_addi:    return rdv + l;
            core_pkg::op_sub:     return rsv - rtv;
            core_pkg::op_subi:    return rdv - l;
            core_pkg::op_mul:     return rsv * rtv;
            core_pkg::op_and:     return rsv & rtv;
            core_pkg::op_or:      return rsv | rtv;
            core_pkg::op_xor:     return rsv ^ rtv;
            core_pkg::op_not:     return ~rsv;
            core_pkg::op_shftr:   return (rtv >= 64) ? 64'd0 : (rsv >> rtv[5:0]);
            core_pkg::op_shftl:   return (rtv >= 64) ? 64'd0 : (rsv << rtv[5:0]);
            core_pkg::op_shftri:  return (l >= 64) ? 64'd0 : (rdv >> l[5:0]);
            core_pkg::op_shftli:  return (l >= 64) ? 64'd0 : (rdv << l[5:0]);
            core_pkg::op_mov_rs:  return rsv;
            core_pkg::op_mov_lit: return {rdv[63:12], lit};
            default:              return 64'd0;
        endcase
    endfunction

    // model executes at drive time and DUT answers two edges later
    task send(input logic [4:0] op, input logic [4:0] rd, input logic [4:0] rs,
              input logic [4:0] rt, input logic [11:0] lit);
        int          kind;
        logic [63:0] res;
        kind = op_kind(op);
        res  = model_result(op, model_regs[rd], model_regs[rs], model_regs[rt], lit);
        if (kind != 0) begin
            exp_slot.push_back(cycle + 2);
            exp_halt.push_back(kind == 2);
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
        if (kind == 1)
            model_regs[rd] = res;
        instr_valid = 1'b1;
        instr       = {op, rd, rs, rt, lit};
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
    endtask

    task idle(input int n);
        instr_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task drain();
        int waited;
        waited = 0;
        instr_valid = 1'b0;
        while (exp_slot.size() > 0 && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_slot.size() > 0) begin
            $display("timeout: %0d writeback slots still pending", exp_slot.size());
            $display("test failed");
            $finish;
        end
        idle(2);   // room for stray slots to show up
    endtask

    task end_test(input string name);
        tests_run++;
        if (err_count == test_base) begin
            $display("[%0d] %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("[%0d] %s: %0d errors", tests_run, name, err_count - test_base);
        end
        test_base = err_count;
    endtask

    // outputs settle mid-cycle so compare on the falling edge
    always @(negedge clk) begin
        if (!reset && (wb_valid || hlt)) begin
            if (exp_slot.size() == 0) begin
                err_count++;
                $display("unexpected writeback slot at %0t, wb_valid %b hlt %b",
                         $time, wb_valid, hlt);
            end else begin
                check_count++;
                if (exp_slot[0] != cycle) begin
                    err_count++;
                    $display("error at %0t: wb cycle got %0d expected %0d",
                             $time, cycle, exp_slot[0]);
                end
                if (hlt !== exp_halt[0]) begin
                    err_count++;
                    $display("error at %0t: hlt got %b expected %b", $time, hlt, exp_halt[0]);
                end
                if (wb_valid !== (exp_halt[0] ? 1'b0 : 1'b1)) begin
                    err_count++;
                    $display("error at %0t: wb_valid got %b expected %b",
                             $time, wb_valid, !exp_halt[0]);
                end
                if (!exp_halt[0] && wb_rd !== exp_rd[0]) begin
                    err_count++;
                    $display("error at %0t: wb_rd got %0d expected %0d", $time, wb_rd, exp_rd[0]);
                end
                if (!exp_halt[0] && wb_data !== exp_data[0]) begin
                    err_count++;
                    $display("error at %0t: wb_data got %h expected %h",
                             $time, wb_data, exp_data[0]);
                end
                void'(exp_slot.pop_front());
                void'(exp_halt.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end else if (!reset && exp_slot.size() > 0 && exp_slot[0] <= cycle) begin
            err_count++;   // slot came and went silent
            $display("missing writeback at %0t, expected in cycle %0d", $time, exp_slot[0]);
            void'(exp_slot.pop_front());
            void'(exp_halt.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
    end

    initial begin
        int          waited;
        int          prev, older;
        logic [4:0]  op;
        $timeformat(-9, 0, " ns", 0);
        seed        = 32'hd9fd;
        instr_valid = 1'b0;
        instr       = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = (r == 31) ? core_pkg::sp_reset_default : 64'd0;

        waited = 0;
        while (reset !== 1'b0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset never released");
            $display("test failed");
            $finish;
        end
        @(posedge clk);
        #2;

        // quiet outputs then stack start and zero readback
        idle(4);
        send(core_pkg::op_mov_rs, 5'd1, 5'd31, 5'd0, 12'd0);
        send(core_pkg::op_mov_rs, 5'd2, 5'd0, 5'd0, 12'd0);
        drain();
        end_test("reset state");

        repeat (8) send(core_pkg::op_mov_lit, pick(32), 5'd0, 5'd0, pick(4096));
        repeat (60) begin
            send(arith_ops[pick(5)], pick(32), pick(32), pick(32), pick(4096));
            if (pick(4) == 0)
                idle(1 + pick(2));
        end
        drain();
        end_test("arithmetic");

        send(core_pkg::op_xor, 5'd7, 5'd7, 5'd7, 12'd0);
        send(core_pkg::op_not, 5'd7, 5'd7, 5'd0, 12'd0);         // all ones to shift
        send(core_pkg::op_mov_lit, 5'd5, 5'd0, 5'd0, 12'd100);   // rt well past 63
        send(core_pkg::op_shftr, 5'd6, 5'd7, 5'd5, 12'd0);
        send(core_pkg::op_shftl, 5'd8, 5'd7, 5'd5, 12'd0);
        send(core_pkg::op_xor, 5'd9, 5'd9, 5'd9, 12'd0);
        send(core_pkg::op_mov_lit, 5'd9, 5'd0, 5'd0, 12'd13);   // small amount
        send(core_pkg::op_shftr, 5'd10, 5'd7, 5'd9, 12'd0);
        send(core_pkg::op_shftl, 5'd12, 5'd7, 5'd9, 12'd0);
        repeat (60) begin
            send(logic_ops[pick(10)], pick(32), pick(32), pick(32),
                 pick(2) ? pick(80) : pick(4096));
            if (pick(4) == 0)
                idle(1 + pick(2));
        end
        drain();
        end_test("logic and shift");

        // chains through forwarding and regfile bypass
        prev  = pick(32);
        older = pick(32);
        repeat (50) begin
            op = pick(2) ? arith_ops[pick(5)] : logic_ops[pick(10)];
            send(op, (pick(4) == 0) ? prev : pick(32), prev,
                 pick(2) ? prev : older, pick(4096));
            older = prev;
            prev  = instr[26:22];   // rd just sent
            case (pick(4))
                0: idle(1);
                1: idle(2);
                default: ;
            endcase
        end
        drain();
        end_test("dependent chains");

        repeat (20) begin
            send(undef_ops[pick(16)], pick(32), pick(32), pick(32), pick(4096));
            if (pick(2) == 0)
                idle(pick(3));
        end
        idle(3);
        send(core_pkg::op_halt, pick(32), pick(32), pick(32), pick(4096));
        idle(3);   // hlt must drop after one slot
        for (int r = 0; r < 32; r++)
            send(core_pkg::op_mov_rs, r, r, 5'd0, 12'd0);   // read back every register
        drain();
        end_test("bubbles and halt");

        $display("tests %0d, with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0 && tests_bad == 0 && check_count > 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock plus power-on reset
module tb_clock_gen #(
    parameter real period       = 20.0,
    parameter int  reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b0;   // release off the edge
    end

endmodule

`default_nettype wire

// File: rtl/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter logic [core_pkg::xlen-1:0] sp_init = core_pkg::sp_reset_default
) (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            instr_valid,
    input  wire logic [core_pkg::instr_w-1:0]    instr,
    output logic                                 wb_valid,
    output logic      [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic      [core_pkg::xlen-1:0]       wb_data,
    output logic                                 hlt
);

    logic [core_pkg::xlen-1:0] arith_result;
    logic [core_pkg::xlen-1:0] logic_result;

    exec_if ex_bus ();   // issue register to execute
    wb_if   wb_bus ();   // writeback register back to issue

    // decode, regfile read, forwarding
    issue_stage #(.sp_init(sp_init)) u_issue (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb_bus.sink),
        .ex          (ex_bus.issue)
    );

    // both units compute every cycle, merge picks one
    arith_unit u_arith (
        .ex     (ex_bus.exec),
        .result (arith_result)
    );

    logic_unit u_logic (
        .ex     (ex_bus.exec),
        .result (logic_result)
    );

    result_merge u_merge (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex_bus.exec),
        .arith_result (arith_result),
        .logic_result (logic_result),
        .wb           (wb_bus.source)
    );

    assign wb_valid = wb_bus.valid;
    assign wb_rd    = wb_bus.rd;
    assign wb_data  = wb_bus.data;
    assign hlt      = wb_bus.halt;

endmodule

`default_nettype wire

// File: rtl/result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module result_merge (
    input  wire logic                      clk,
    input  wire logic                      reset,
    exec_if.exec                           ex,
    input  wire logic [core_pkg::xlen-1:0] arith_result,
    input  wire logic [core_pkg::xlen-1:0] logic_result,
    wb_if.source                           wb
);

    logic                      writes_rd;
    logic                      is_halt;
    logic [core_pkg::xlen-1:0] sel_data;

    // only real arith and logic ops write back
    assign writes_rd = ex.valid &&
                       ((ex.cls == core_pkg::class_arith) ||
                        (ex.cls == core_pkg::class_logic));
    assign is_halt   = ex.valid && (ex.cls == core_pkg::class_halt);

    always_comb begin
        case (ex.cls)
            core_pkg::class_arith: sel_data = arith_result;
            core_pkg::class_logic: sel_data = logic_result;
            default:               sel_data = '0;   // halt and bubbles carry no data
        endcase
    end

    // writeback register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb.valid <= 1'b0;
            wb.halt  <= 1'b0;
            wb.rd    <= '0;
            wb.data  <= '0;
        end else begin
            wb.valid <= writes_rd;
            wb.halt  <= is_halt;   // one cycle, halt slot
            wb.rd    <= ex.rd;
            wb.data  <= sel_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/logic_unit.sv
`timescale 1ns/1ps
`default_nettype none

module logic_unit (
    exec_if.exec                        ex,
    output logic [core_pkg::xlen-1:0]   result
);

    logic [core_pkg::xlen-1:0] mov_lit_val;
    logic                      big_shift;

    // mov rd,L only touches the low literal bits
    assign mov_lit_val = {ex.rd_val[core_pkg::xlen-1:core_pkg::lit_w], ex.lit};

    // register shift amount is all 64 bits of rt
    assign big_shift = (ex.rt_val >= core_pkg::xlen);

    always_comb begin
        case (ex.op)
            core_pkg::op_and: result = ex.rs_val & ex.rt_val;
            core_pkg::op_or:  result = ex.rs_val | ex.rt_val;
            core_pkg::op_xor: result = ex.rs_val ^ ex.rt_val;
            core_pkg::op_not: result = ~ex.rs_val;             // rt ignored

            core_pkg::op_shftr:
                result = big_shift ? '0 : (ex.rs_val >> ex.rt_val[5:0]);
            core_pkg::op_shftl:
                result = big_shift ? '0 : (ex.rs_val << ex.rt_val[5:0]);

            // literal shifts work on rd in place, 64 and up clears
            core_pkg::op_shftri: result = ex.rd_val >> ex.lit;
            core_pkg::op_shftli: result = ex.rd_val << ex.lit;

            core_pkg::op_mov_rs:  result = ex.rs_val;
            core_pkg::op_mov_lit: result = mov_lit_val;
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
    exec_if.exec                        ex,
    output logic [core_pkg::xlen-1:0]   result
);

    logic [core_pkg::xlen-1:0] lit_ext;

    // literal is unsigned here
    assign lit_ext = {{(core_pkg::xlen - core_pkg::lit_w){1'b0}}, ex.lit};

    always_comb begin
        case (ex.op)
            core_pkg::op_add:  result = ex.rs_val + ex.rt_val;
            core_pkg::op_addi: result = ex.rd_val + lit_ext;   // rd += L
            core_pkg::op_sub:  result = ex.rs_val - ex.rt_val;
            core_pkg::op_subi: result = ex.rd_val - lit_ext;   // rd -= L
            core_pkg::op_mul:  result = ex.rs_val * ex.rt_val; // low 64 bits only
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
    parameter logic [core_pkg::xlen-1:0] sp_init = core_pkg::sp_reset_default
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         instr_valid,
    input  wire logic [core_pkg::instr_w-1:0] instr,
    wb_if.sink                                wb,
    exec_if.issue                             ex
);

    core_pkg::opcode_t               dec_op;
    core_pkg::op_class_t             dec_cls;
    logic [core_pkg::reg_addr_w-1:0] dec_rd, dec_rs, dec_rt;
    logic [core_pkg::lit_w-1:0]      dec_lit;
    logic [core_pkg::xlen-1:0]       rf_rd, rf_rs, rf_rt;

    // issue register
    logic                            iss_valid;
    core_pkg::op_class_t             iss_cls;
    core_pkg::opcode_t               iss_op;
    logic [core_pkg::reg_addr_w-1:0] iss_rd, iss_rs, iss_rt;
    logic [core_pkg::lit_w-1:0]      iss_lit;
    logic [core_pkg::xlen-1:0]       iss_rd_val, iss_rs_val, iss_rt_val;

    assign dec_op  = core_pkg::opcode_t'(instr[core_pkg::op_lsb +: core_pkg::opcode_w]);
    assign dec_rd  = instr[core_pkg::rd_lsb +: core_pkg::reg_addr_w];
    assign dec_rs  = instr[core_pkg::rs_lsb +: core_pkg::reg_addr_w];
    assign dec_rt  = instr[core_pkg::rt_lsb +: core_pkg::reg_addr_w];
    assign dec_lit = instr[core_pkg::lit_w-1:0];

    always_comb begin
        case (dec_op)
            core_pkg::op_add, core_pkg::op_addi, core_pkg::op_sub,
            core_pkg::op_subi, core_pkg::op_mul:
                dec_cls = core_pkg::class_arith;
            core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor, core_pkg::op_not,
            core_pkg::op_shftr, core_pkg::op_shftri, core_pkg::op_shftl,
            core_pkg::op_shftli, core_pkg::op_mov_rs, core_pkg::op_mov_lit:
                dec_cls = core_pkg::class_logic;
            core_pkg::op_halt:
                dec_cls = core_pkg::class_halt;
            default:
                dec_cls = core_pkg::class_none;   // unknown opcode rides as bubble
        endcase
    end

    // writeback port doubles as regfile write, bypass covers two slots back
    reg_file #(.sp_init(sp_init)) u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .we      (wb.valid),
        .wr_addr (wb.rd),
        .wr_data (wb.data),
        .rd_addr (dec_rd),
        .rs_addr (dec_rs),
        .rt_addr (dec_rt),
        .rd_data (rf_rd),
        .rs_data (rf_rs),
        .rt_data (rf_rt)
    );

    // control half, idle cycle becomes a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iss_valid <= 1'b0;
            iss_cls   <= core_pkg::class_none;
        end else begin
            iss_valid <= instr_valid;
            iss_cls   <= instr_valid ? dec_cls : core_pkg::class_none;
        end
    end

    // payload half, only loaded on a real instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            iss_op     <= dec_op;
            iss_rd     <= dec_rd;
            iss_rs     <= dec_rs;
            iss_rt     <= dec_rt;
            iss_lit    <= dec_lit;
            iss_rd_val <= rf_rd;
            iss_rs_val <= rf_rs;
            iss_rt_val <= rf_rt;
        end
    end

    assign ex.valid = iss_valid;
    assign ex.cls   = iss_cls;
    assign ex.op    = iss_op;
    assign ex.rd    = iss_rd;
    assign ex.rs    = iss_rs;
    assign ex.rt    = iss_rt;
    assign ex.lit   = iss_lit;

    // newest result is the one sitting in writeback, one slot ahead
    assign ex.rd_val = (wb.valid && (wb.rd == iss_rd)) ? wb.data : iss_rd_val;
    assign ex.rs_val = (wb.valid && (wb.rd == iss_rs)) ? wb.data : iss_rs_val;
    assign ex.rt_val = (wb.valid && (wb.rd == iss_rt)) ? wb.data : iss_rt_val;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter logic [core_pkg::xlen-1:0] sp_init = core_pkg::sp_reset_default
) (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            we,
    input  wire logic [core_pkg::reg_addr_w-1:0] wr_addr,
    input  wire logic [core_pkg::xlen-1:0]       wr_data,
    input  wire logic [core_pkg::reg_addr_w-1:0] rd_addr,
    input  wire logic [core_pkg::reg_addr_w-1:0] rs_addr,
    input  wire logic [core_pkg::reg_addr_w-1:0] rt_addr,
    output logic      [core_pkg::xlen-1:0]       rd_data,
    output logic      [core_pkg::xlen-1:0]       rs_data,
    output logic      [core_pkg::xlen-1:0]       rt_data
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];

    // top register is the stack pointer, rest start at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::num_regs; i++) begin
                if (i == core_pkg::num_regs - 1)
                    regs[i] <= sp_init;
                else
                    regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-first, a same-cycle write wins over the stored word
    assign rd_data = (we && (wr_addr == rd_addr)) ? wr_data : regs[rd_addr];
    assign rs_data = (we && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
    assign rt_data = (we && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// File: rtl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// writeback result, fed back to issue for regfile write and forwarding
interface wb_if;

    logic                                valid;   // writes rd
    logic [core_pkg::reg_addr_w-1:0]     rd;
    logic [core_pkg::xlen-1:0]           data;
    logic                                halt;    // halt slot, no write

    modport source (
        output valid, rd, data, halt
    );

    modport sink (
        input valid, rd, data, halt
    );

endinterface

`default_nettype wire

// File: rtl/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

// one issued instruction, operands already forwarded
interface exec_if;

    logic                                valid;
    core_pkg::opcode_t                   op;
    core_pkg::op_class_t                 cls;
    logic [core_pkg::reg_addr_w-1:0]     rd;
    logic [core_pkg::reg_addr_w-1:0]     rs;
    logic [core_pkg::reg_addr_w-1:0]     rt;
    logic [core_pkg::lit_w-1:0]          lit;
    logic [core_pkg::xlen-1:0]           rd_val;   // old rd, for literal forms
    logic [core_pkg::xlen-1:0]           rs_val;
    logic [core_pkg::xlen-1:0]           rt_val;

    modport issue (
        output valid, op, cls, rd, rs, rt, lit, rd_val, rs_val, rt_val
    );

    modport exec (
        input valid, op, cls, rd, rs, rt, lit, rd_val, rs_val, rt_val
    );

endinterface

`default_nettype wire

// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    // datapath and instruction widths
    localparam int xlen       = 64;
    localparam int instr_w    = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int lit_w      = 12;
    localparam int opcode_w   = 5;

    // field positions inside the instruction word
    localparam int op_lsb = 27;   // opcode in 31..27
    localparam int rd_lsb = 22;   // rd in 26..22
    localparam int rs_lsb = 17;   // rs in 21..17
    localparam int rt_lsb = 12;   // rt in 16..12

    // kept opcodes, encodings as in the full core
    typedef enum logic [opcode_w-1:0] {
        op_and     = 5'h00,
        op_or      = 5'h01,
        op_xor     = 5'h02,
        op_not     = 5'h03,
        op_shftr   = 5'h04,
        op_shftri  = 5'h05,
        op_shftl   = 5'h06,
        op_shftli  = 5'h07,
        op_halt    = 5'h0F,
        op_mov_rs  = 5'h11,
        op_mov_lit = 5'h12,
        op_add     = 5'h18,
        op_addi    = 5'h19,
        op_sub     = 5'h1A,
        op_subi    = 5'h1B,
        op_mul     = 5'h1C
    } opcode_t;

    // which unit produces the result
    typedef enum logic [1:0] {
        class_none,     // bubble or unknown opcode
        class_arith,
        class_logic,
        class_halt
    } op_class_t;

    localparam logic [xlen-1:0] sp_reset_default = 64'h0008_0000;   // stack start

endpackage

`default_nettype wire
